//--- build.f
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_mem_wb.sv
rtl/riscv_top.sv
dv/tb_riscv_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_riscv_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_top import rv_pkg::*; ();

	localparam int IMEM_ADDR_W = 12;
	localparam int DMEM_ADDR_W = 12;
	localparam int IMEM_WORDS  = 1 << (IMEM_ADDR_W - 2);
	localparam int DMEM_WORDS  = 1 << DMEM_ADDR_W;
	localparam int TIMEOUT     = 200;   // cycles per wait
	localparam word_t SENTINEL = 32'h5e47_1e11;
	localparam logic [6:0] I_ARITH = 7'b0010011;
	localparam logic [6:0] I_LOAD  = 7'b0000011;
	localparam logic [6:0] I_JALR  = 7'b1100111;

	logic                   CLK;
	logic                   RSTn;
	logic                   I_MEM_CSN;
	word_t                  I_MEM_DI;
	logic [IMEM_ADDR_W-1:0] I_MEM_ADDR;
	logic                   D_MEM_CSN;
	word_t                  D_MEM_DI;
	word_t                  D_MEM_DOUT;
	logic [DMEM_ADDR_W-1:0] D_MEM_ADDR;
	logic                   D_MEM_WEN;
	logic [3:0]             D_MEM_BE;
	logic                   RF_WE;
	reg_idx_t               RF_RA1;
	reg_idx_t               RF_RA2;
	reg_idx_t               RF_WA1;
	word_t                  RF_RD1;
	word_t                  RF_RD2;
	word_t                  RF_WD;
	word_t                  NUM_INST;

	word_t  imem [0:IMEM_WORDS-1];
	word_t  dmem [0:DMEM_WORDS-1];
	word_t  rf [0:31];
	word_t  init_dmem [0:DMEM_WORDS-1];
	word_t  init_rf [0:31];
	logic   preload;   // copies init arrays into the models
	word_t  be_mask;
	int     errors = 0;
	int     checks = 0;
	integer seed = 32'hd7c1f19b;

	riscv_top #(.IMEM_ADDR_W(IMEM_ADDR_W), .DMEM_ADDR_W(DMEM_ADDR_W)) DUT (.*);

	always #2 CLK = ~CLK;

	//////////////////////////////////////////////////////////////////////
	// memory and register file models

	assign I_MEM_DI = imem[I_MEM_ADDR[IMEM_ADDR_W-1:2]];
	assign D_MEM_DI = dmem[D_MEM_ADDR];
	assign RF_RD1   = (RF_RA1 == '0) ? '0 : rf[RF_RA1];   // x0 reads zero
	assign RF_RD2   = (RF_RA2 == '0) ? '0 : rf[RF_RA2];
	assign be_mask  = {{8{D_MEM_BE[3]}}, {8{D_MEM_BE[2]}}, {8{D_MEM_BE[1]}}, {8{D_MEM_BE[0]}}};

	always @(posedge CLK) begin
		if (preload) begin
			for (int i = 0; i < 32; i++)
				rf[5'(i)] <= init_rf[5'(i)];
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[12'(i)] <= init_dmem[12'(i)];
		end else begin
			if (RF_WE)
				rf[RF_WA1] <= RF_WD;   // old value seen by reads this cycle
			if (!D_MEM_CSN && !D_MEM_WEN)
				dmem[D_MEM_ADDR] <= (dmem[D_MEM_ADDR] & ~be_mask) | (D_MEM_DOUT & be_mask);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// instruction encoders

	function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
		logic [11:0] v;
		v = 12'(imm);
		return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
		input int off);
		logic [12:0] v;
		v = 13'(off);
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], 7'b1100011};
	endfunction

	function automatic word_t enc_jal(input int rd, input int off);
		logic [20:0] v;
		v = 21'(off);
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
	endfunction

	// ISA branch conditions
	function automatic logic branch_rule(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks and sequencing

	task automatic check_eq(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_reg(input int idx, input word_t exp);
		check_eq($sformatf("x%0d", idx), rf[5'(idx)], exp);
	endtask

	task automatic clear_program();
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[10'(i)] = '0;   // zero word decodes to a bubble
		for (int i = 0; i < 32; i++)
			init_rf[5'(i)] = '0;
	endtask

	task automatic check_reset_state();
		check_eq("I_MEM_ADDR", 32'(I_MEM_ADDR), 32'd0);
		check_eq("NUM_INST", NUM_INST, 32'd0);
		check_eq("RF_WE", 32'(RF_WE), 32'd0);
		check_eq("D_MEM_WEN", 32'(D_MEM_WEN), 32'd1);
		check_eq("D_MEM_BE", 32'(D_MEM_BE), 32'd0);
		check_eq("I_MEM_CSN", 32'(I_MEM_CSN), 32'd1);
		check_eq("D_MEM_CSN", 32'(D_MEM_CSN), 32'd1);
	endtask

	// 8 reset cycles with the models loaded midway
	task automatic reset_dut();
		@(posedge CLK);
		RSTn <= 1'b1;
		repeat (3) @(posedge CLK);
		preload <= 1'b1;
		@(posedge CLK);
		preload <= 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		check_reset_state();
		@(posedge CLK);
		RSTn <= 1'b0;
	endtask

	task automatic wait_retired(input int count);
		int cycles = 0;
		while ((NUM_INST != 32'(count)) && (cycles < TIMEOUT)) begin
			@(negedge CLK);
			cycles++;
		end
		assert (NUM_INST == 32'(count)) else begin
			errors++;
			$display("timeout: %0d instructions not retired within %0d cycles", count, TIMEOUT);
		end
		if (NUM_INST == 32'(count)) begin
			repeat (6) @(negedge CLK);   // nothing else may retire
			check_eq("NUM_INST", NUM_INST, 32'(count));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic test_reset_and_fetch();
		clear_program();
		for (int i = 0; i < 8; i++)
			imem[10'(i)] = enc_i(I_ARITH, 3'b000, 5, 5, 1);
		reset_dut();
		for (int i = 0; i < 10; i++) begin
			@(negedge CLK);
			check_eq("I_MEM_ADDR", 32'(I_MEM_ADDR), 32'(4 * i));
			if (i == 0) begin
				check_eq("I_MEM_CSN", 32'(I_MEM_CSN), 32'd0);
				check_eq("D_MEM_CSN", 32'(D_MEM_CSN), 32'd0);
			end
		end
		wait_retired(8);
		check_reg(5, 32'd8);
	endtask

	task automatic test_alu_chain();
		word_t e [0:31];
		for (int r = 0; r < 32; r++)
			e[5'(r)] = '0;
		clear_program();
		for (int r = 1; r <= 4; r++) begin
			e[5'(r)] = $random(seed);
			init_rf[5'(r)] = e[5'(r)];
		end
		imem[0]  = enc_r(7'h00, 3'b000, 5, 1, 2);
		imem[1]  = enc_r(7'h20, 3'b000, 6, 5, 3);
		imem[2]  = enc_r(7'h00, 3'b100, 7, 6, 5);
		imem[3]  = enc_r(7'h00, 3'b110, 8, 7, 5);
		imem[4]  = enc_r(7'h00, 3'b111, 9, 8, 6);
		imem[5]  = enc_r(7'h00, 3'b010, 10, 9, 7);
		imem[6]  = enc_r(7'h00, 3'b011, 11, 10, 8);
		imem[7]  = enc_r(7'h00, 3'b001, 12, 9, 5);
		imem[8]  = enc_r(7'h00, 3'b101, 13, 12, 2);
		imem[9]  = enc_r(7'h20, 3'b101, 14, 12, 3);
		imem[10] = enc_i(I_ARITH, 3'b000, 15, 14, -5);
		imem[11] = enc_i(I_ARITH, 3'b010, 16, 14, 100);
		imem[12] = enc_i(I_ARITH, 3'b011, 17, 15, -1);
		imem[13] = enc_i(I_ARITH, 3'b100, 18, 15, 'h5a5);
		imem[14] = enc_i(I_ARITH, 3'b110, 19, 18, -256);
		imem[15] = enc_i(I_ARITH, 3'b111, 20, 19, 'h7f0);
		imem[16] = enc_i(I_ARITH, 3'b001, 21, 20, 7);
		imem[17] = enc_i(I_ARITH, 3'b101, 22, 19, 9);
		imem[18] = enc_i(I_ARITH, 3'b101, 23, 21, 'h400 + 13);   // srai
		imem[19] = enc_r(7'h00, 3'b000, 0, 23, 22);   // write to x0 is dropped
		imem[20] = enc_r(7'h00, 3'b000, 24, 0, 23);
		e[5]  = e[1] + e[2];
		e[6]  = e[5] - e[3];
		e[7]  = e[6] ^ e[5];
		e[8]  = e[7] | e[5];
		e[9]  = e[8] & e[6];
		e[10] = {31'b0, $signed(e[9]) < $signed(e[7])};
		e[11] = {31'b0, e[10] < e[8]};
		e[12] = e[9] << e[5][4:0];
		e[13] = e[12] >> e[2][4:0];
		e[14] = $signed(e[12]) >>> e[3][4:0];
		e[15] = e[14] - 32'd5;
		e[16] = {31'b0, $signed(e[14]) < 32'sd100};
		e[17] = {31'b0, e[15] < 32'hffff_ffff};
		e[18] = e[15] ^ 32'h5a5;
		e[19] = e[18] | 32'hffff_ff00;
		e[20] = e[19] & 32'h7f0;
		e[21] = e[20] << 7;
		e[22] = e[19] >> 9;
		e[23] = $signed(e[21]) >>> 13;
		e[24] = e[23];
		reset_dut();
		wait_retired(21);
		for (int r = 0; r < 32; r++)
			check_reg(r, e[5'(r)]);
	endtask

	task automatic test_load_use();
		word_t addr;
		clear_program();
		init_rf[1] = 32'h100;
		init_rf[2] = 32'hcafe_f00d;
		imem[0] = enc_sw(2, 1, 8);
		imem[1] = enc_i(I_LOAD, 3'b010, 3, 1, 8);
		imem[2] = enc_r(7'h00, 3'b000, 4, 3, 1);   // needs the load result
		imem[3] = enc_i(I_ARITH, 3'b000, 5, 4, 1);
		addr = (32'h100 + 32'd8) >> 2;
		reset_dut();
		wait_retired(4);
		check_eq("dmem[0x42]", dmem[12'(addr)], 32'hcafe_f00d);
		check_eq("dmem[0x43]", dmem[12'(addr + 1)], init_dmem[12'(addr + 1)]);
		check_reg(3, 32'hcafe_f00d);
		check_reg(4, 32'hcafe_f00d + 32'h100);
		check_reg(5, 32'hcafe_f00d + 32'h101);
	endtask

	task automatic test_branches();
		word_t      a_vals [0:2];
		word_t      b_vals [0:2];
		logic [2:0] f3s [0:5];
		logic       taken;
		a_vals = '{32'hffff_fffb, 32'd3, 32'd3};
		b_vals = '{32'd3, 32'd3, 32'hffff_fffb};
		f3s    = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		for (int p = 0; p < 3; p++) begin
			for (int k = 0; k < 6; k++) begin
				clear_program();
				init_rf[1]  = a_vals[p];
				init_rf[2]  = b_vals[p];
				init_rf[10] = SENTINEL;
				init_rf[11] = SENTINEL;
				imem[0] = enc_b(f3s[k], 1, 2, 12);
				imem[1] = enc_i(I_ARITH, 3'b000, 10, 0, 'h11);
				imem[2] = enc_i(I_ARITH, 3'b000, 11, 0, 'h22);
				imem[3] = enc_i(I_ARITH, 3'b000, 12, 0, 'h33);
				taken = branch_rule(f3s[k], a_vals[p], b_vals[p]);
				reset_dut();
				wait_retired(taken ? 2 : 4);
				check_eq($sformatf("x10 f3=%0d a=%h b=%h", f3s[k], a_vals[p], b_vals[p]),
					rf[10], taken ? SENTINEL : 32'h11);
				check_eq($sformatf("x11 f3=%0d a=%h b=%h", f3s[k], a_vals[p], b_vals[p]),
					rf[11], taken ? SENTINEL : 32'h22);
				check_reg(12, 32'h33);
			end
		end
	endtask

	task automatic test_jumps();
		clear_program();
		for (int r = 10; r <= 13; r++)
			init_rf[5'(r)] = SENTINEL;
		imem[0]  = enc_jal(1, 12);
		imem[1]  = enc_i(I_ARITH, 3'b000, 10, 0, 'h11);
		imem[2]  = enc_i(I_ARITH, 3'b000, 11, 0, 'h22);
		imem[3]  = enc_i(I_ARITH, 3'b000, 5, 0, 'h21);
		imem[4]  = enc_i(I_JALR, 3'b000, 2, 5, 16);   // odd sum 0x31
		imem[5]  = enc_i(I_ARITH, 3'b000, 12, 0, 'h44);
		imem[6]  = enc_i(I_ARITH, 3'b000, 13, 0, 'h55);
		imem[12] = enc_jal(3, 8);   // link shows whether bit 0 was cleared
		imem[13] = enc_i(I_ARITH, 3'b000, 12, 0, 'h66);
		imem[14] = enc_i(I_ARITH, 3'b000, 14, 1, 'h100);
		imem[15] = enc_r(7'h00, 3'b000, 15, 2, 3);
		reset_dut();
		wait_retired(6);
		check_reg(1, 32'h0 + 32'd4);
		check_reg(2, 32'h10 + 32'd4);
		check_reg(3, ((32'h21 + 32'd16) & ~32'd1) + 32'd4);
		check_reg(5, 32'h21);
		for (int r = 10; r <= 13; r++)
			check_reg(r, SENTINEL);
		check_reg(14, 32'h4 + 32'h100);
		check_reg(15, 32'h14 + 32'h34);
	endtask

	//////////////////////////////////////////////////////////////////////

	initial begin
		CLK     = 1'b0;
		RSTn    = 1'b1;
		preload = 1'b0;
		for (int i = 0; i < DMEM_WORDS; i++)
			init_dmem[12'(i)] = {20'hd5a00, 12'(i)};
		test_reset_and_fetch();
		test_alu_chain();
		test_load_use();
		test_branches();
		test_jumps();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/riscv_top.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_top import rv_pkg::*; #(
	parameter int IMEM_ADDR_W = 12,
	parameter int DMEM_ADDR_W = 12
) (
	input  wire                    CLK,
	input  wire                    RSTn,
	// instruction memory
	output logic                   I_MEM_CSN,
	input  wire word_t             I_MEM_DI,
	output logic [IMEM_ADDR_W-1:0] I_MEM_ADDR,   // byte address
	// data memory
	output logic                   D_MEM_CSN,
	input  wire word_t             D_MEM_DI,
	output word_t                  D_MEM_DOUT,
	output logic [DMEM_ADDR_W-1:0] D_MEM_ADDR,   // word address
	output logic                   D_MEM_WEN,
	output logic [3:0]             D_MEM_BE,
	// register file
	output logic                   RF_WE,
	output reg_idx_t               RF_RA1,
	output reg_idx_t               RF_RA2,
	output reg_idx_t               RF_WA1,
	input  wire word_t             RF_RD1,
	input  wire word_t             RF_RD2,
	output word_t                  RF_WD,
	output word_t                  NUM_INST
);

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	logic      stall;
	logic      redirect;
	word_t     redirect_pc;
	rf_write_t ex_fwd;
	rf_write_t wb_fwd;
	rf_write_t last_fwd;

	assign I_MEM_CSN = RSTn;
	assign D_MEM_CSN = RSTn;

	rv_fetch #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_fetch (
		.CLK(CLK), .RSTn(RSTn), .stall(stall), .redirect(redirect),
		.redirect_pc(redirect_pc), .I_MEM_DI(I_MEM_DI),
		.I_MEM_ADDR(I_MEM_ADDR), .if_id(if_id)
	);

	rv_decode u_decode (
		.CLK(CLK), .RSTn(RSTn), .if_id(if_id), .redirect(redirect),
		.RF_RD1(RF_RD1), .RF_RD2(RF_RD2), .RF_RA1(RF_RA1), .RF_RA2(RF_RA2),
		.stall(stall), .id_ex(id_ex)
	);

	rv_execute u_execute (
		.CLK(CLK), .RSTn(RSTn), .id_ex(id_ex),
		.ex_fwd(ex_fwd), .wb_fwd(wb_fwd), .last_fwd(last_fwd),
		.redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
	);

	rv_mem_wb #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_mem_wb (
		.CLK(CLK), .RSTn(RSTn), .ex_mem(ex_mem), .D_MEM_DI(D_MEM_DI),
		.D_MEM_ADDR(D_MEM_ADDR), .D_MEM_DOUT(D_MEM_DOUT),
		.D_MEM_WEN(D_MEM_WEN), .D_MEM_BE(D_MEM_BE),
		.RF_WE(RF_WE), .RF_WA1(RF_WA1), .RF_WD(RF_WD),
		.ex_fwd(ex_fwd), .wb_fwd(wb_fwd), .last_fwd(last_fwd),
		.NUM_INST(NUM_INST)
	);

endmodule

`default_nettype wire

//--- rtl/rv_mem_wb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_mem_wb import rv_pkg::*; #(
	parameter int DMEM_ADDR_W = 12
) (
	input  wire                    CLK,
	input  wire                    RSTn,
	input  wire ex_mem_t           ex_mem,
	input  wire word_t             D_MEM_DI,
	output logic [DMEM_ADDR_W-1:0] D_MEM_ADDR,
	output word_t                  D_MEM_DOUT,
	output logic                   D_MEM_WEN,
	output logic [3:0]             D_MEM_BE,
	output logic                   RF_WE,
	output reg_idx_t               RF_WA1,
	output word_t                  RF_WD,
	output rf_write_t              ex_fwd,
	output rf_write_t              wb_fwd,
	output rf_write_t              last_fwd,
	output word_t                  NUM_INST
);

	logic is_store;
	logic wb_retire;

	assign is_store   = ex_mem.valid && (ex_mem.opcode == OPC_STORE);
	assign D_MEM_ADDR = ex_mem.result[DMEM_ADDR_W+1:2];   // word address
	assign D_MEM_DOUT = ex_mem.store_data;
	assign D_MEM_WEN  = !is_store;
	assign D_MEM_BE   = {4{is_store}};

	assign ex_fwd.valid = ex_mem.valid && ex_mem.rd_we;
	assign ex_fwd.rd    = ex_mem.rd;
	assign ex_fwd.data  = ex_mem.result;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wb_fwd.valid   <= 1'b0;
			last_fwd.valid <= 1'b0;
			wb_retire      <= 1'b0;
		end else begin
			wb_fwd.valid <= ex_mem.valid && ex_mem.rd_we;
			wb_fwd.rd    <= ex_mem.rd;
			wb_fwd.data  <= (ex_mem.opcode == OPC_LOAD) ? D_MEM_DI : ex_mem.result;
			wb_retire    <= ex_mem.valid;
			last_fwd     <= wb_fwd;   // copy of what the rf takes this edge
		end
	end

	assign RF_WE  = wb_fwd.valid;
	assign RF_WA1 = wb_fwd.rd;
	assign RF_WD  = wb_fwd.data;

	always_ff @(posedge CLK) begin
		if (RSTn)
			NUM_INST <= '0;
		else if (wb_retire)
			NUM_INST <= NUM_INST + 32'd1;
	end

	a_no_x0_write: assert property (@(posedge CLK) disable iff (RSTn)
		RF_WE |-> (RF_WA1 != '0));

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute import rv_pkg::*; (
	input  wire            CLK,
	input  wire            RSTn,
	input  wire id_ex_t    id_ex,
	input  wire rf_write_t ex_fwd,
	input  wire rf_write_t wb_fwd,
	input  wire rf_write_t last_fwd,
	output logic           redirect,
	output word_t          redirect_pc,
	output ex_mem_t        ex_mem
);

	word_t op_a;
	word_t rs2_v;
	word_t op_b;
	word_t alu_res;
	word_t jalr_sum;
	logic  cond;
	logic  taken;

	// youngest result wins, x0 never forwarded
	function automatic word_t fwd_sel(input reg_idx_t idx, input word_t rf_val);
		word_t v;
		if (idx == '0)
			v = rf_val;
		else if (ex_fwd.valid && (ex_fwd.rd == idx))
			v = ex_fwd.data;
		else if (wb_fwd.valid && (wb_fwd.rd == idx))
			v = wb_fwd.data;
		else if (last_fwd.valid && (last_fwd.rd == idx))
			v = last_fwd.data;   // rf write in flight
		else
			v = rf_val;
		return v;
	endfunction

	assign op_a  = fwd_sel(id_ex.rs1, id_ex.rs1_val);
	assign rs2_v = fwd_sel(id_ex.rs2, id_ex.rs2_val);
	assign op_b  = id_ex.use_imm ? id_ex.imm : rs2_v;

	//////////////////////////////////////////////////////////////////////
	// alu

	always_comb begin
		case (id_ex.alu_op)
			ALU_SUB:       alu_res = op_a - op_b;
			ALU_SLT:       alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:      alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:       alu_res = op_a ^ op_b;
			ALU_OR:        alu_res = op_a | op_b;
			ALU_AND:       alu_res = op_a & op_b;
			ALU_SLL:       alu_res = op_a << op_b[4:0];
			ALU_SRL:       alu_res = op_a >> op_b[4:0];
			ALU_SRA:       alu_res = $signed(op_a) >>> op_b[4:0];
			ALU_PASS_LINK: alu_res = id_ex.pc + 32'd4;
			default:       alu_res = op_a + op_b;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// branch and jump resolution

	always_comb begin
		case (id_ex.funct3)
			3'b000:  cond = (op_a == rs2_v);
			3'b001:  cond = (op_a != rs2_v);
			3'b100:  cond = $signed(op_a) < $signed(rs2_v);
			3'b101:  cond = $signed(op_a) >= $signed(rs2_v);
			3'b110:  cond = op_a < rs2_v;
			3'b111:  cond = op_a >= rs2_v;
			default: cond = 1'b0;
		endcase
	end

	assign taken = (id_ex.opcode == OPC_BRANCH) ? cond :
		((id_ex.opcode == OPC_JAL) || (id_ex.opcode == OPC_JALR));

	assign jalr_sum    = op_a + id_ex.imm;
	assign redirect    = id_ex.valid && taken;
	assign redirect_pc = (id_ex.opcode == OPC_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} :
		(id_ex.pc + id_ex.imm);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			ex_mem.valid <= 1'b0;
		end else begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.opcode     <= id_ex.opcode;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.rd_we      <= id_ex.rd_we;
			ex_mem.result     <= alu_res;
			ex_mem.store_data <= rs2_v;
		end
	end

	a_target_aligned: assert property (@(posedge CLK) disable iff (RSTn)
		redirect |-> (redirect_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode import rv_pkg::*; (
	input  wire            CLK,
	input  wire            RSTn,
	input  wire if_id_t    if_id,
	input  wire            redirect,
	input  wire word_t     RF_RD1,
	input  wire word_t     RF_RD2,
	output reg_idx_t       RF_RA1,
	output reg_idx_t       RF_RA2,
	output logic           stall,
	output id_ex_t         id_ex
);

	word_t  inst;
	word_t  imm_i;
	word_t  imm_s;
	word_t  imm_b;
	word_t  imm_j;
	logic   use_rs1;
	logic   use_rs2;
	logic   wr_rd;
	logic   legal;
	id_ex_t dec;

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign inst  = if_id.instr;
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	//////////////////////////////////////////////////////////////////////
	// opcode decode

	always_comb begin
		use_rs1    = 1'b0;
		use_rs2    = 1'b0;
		wr_rd      = 1'b0;
		legal      = 1'b1;
		dec        = '0;
		dec.opcode = OPC_OP;
		dec.alu_op = ALU_ADD;
		case (inst[6:0])
			OPC_OP: begin
				dec.opcode = OPC_OP;
				dec.alu_op = alu_sel(inst[14:12], inst[30]);
				use_rs1    = 1'b1;
				use_rs2    = 1'b1;
				wr_rd      = 1'b1;
			end
			OPC_OP_IMM: begin
				dec.opcode  = OPC_OP_IMM;
				// only the shifts use bit 30
				dec.alu_op  = alu_sel(inst[14:12], (inst[14:12] == 3'b101) && inst[30]);
				dec.imm     = imm_i;
				dec.use_imm = 1'b1;
				use_rs1     = 1'b1;
				wr_rd       = 1'b1;
			end
			OPC_LOAD: begin
				dec.opcode  = OPC_LOAD;
				dec.imm     = imm_i;
				dec.use_imm = 1'b1;
				use_rs1     = 1'b1;
				wr_rd       = 1'b1;
				legal       = (inst[14:12] == 3'b010);   // LW only
			end
			OPC_STORE: begin
				dec.opcode  = OPC_STORE;
				dec.imm     = imm_s;
				dec.use_imm = 1'b1;
				use_rs1     = 1'b1;
				use_rs2     = 1'b1;
				legal       = (inst[14:12] == 3'b010);   // SW only
			end
			OPC_BRANCH: begin
				dec.opcode = OPC_BRANCH;
				dec.imm    = imm_b;
				use_rs1    = 1'b1;
				use_rs2    = 1'b1;
				legal      = (inst[14:13] != 2'b01);
			end
			OPC_JAL: begin
				dec.opcode = OPC_JAL;
				dec.alu_op = ALU_PASS_LINK;
				dec.imm    = imm_j;
				wr_rd      = 1'b1;
			end
			OPC_JALR: begin
				dec.opcode = OPC_JALR;
				dec.alu_op = ALU_PASS_LINK;
				dec.imm    = imm_i;
				use_rs1    = 1'b1;
				wr_rd      = 1'b1;
			end
			default: legal = 1'b0;   // becomes a bubble
		endcase

		RF_RA1 = (legal && use_rs1) ? inst[19:15] : '0;
		RF_RA2 = (legal && use_rs2) ? inst[24:20] : '0;

		dec.valid   = if_id.valid && legal;
		dec.funct3  = inst[14:12];
		dec.rs1     = RF_RA1;
		dec.rs2     = RF_RA2;
		dec.rd      = inst[11:7];
		dec.rd_we   = legal && wr_rd && (inst[11:7] != '0);
		dec.rs1_val = RF_RD1;
		dec.rs2_val = RF_RD2;
		dec.pc      = if_id.pc;
	end

	// load-use hazard against the instruction now in execute
	assign stall = if_id.valid && id_ex.valid && (id_ex.opcode == OPC_LOAD) && id_ex.rd_we &&
		(((RF_RA1 != '0) && (RF_RA1 == id_ex.rd)) ||
		 ((RF_RA2 != '0) && (RF_RA2 == id_ex.rd)));

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex <= dec;
			if (stall || redirect)
				id_ex.valid <= 1'b0;
		end
	end

	// fetch re-presents the stalled instruction
	a_stall_hold: assert property (@(posedge CLK) disable iff (RSTn)
		stall |=> $stable(if_id));

endmodule

`default_nettype wire

//--- rtl/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
	parameter int IMEM_ADDR_W = 12
) (
	input  wire                    CLK,
	input  wire                    RSTn,
	input  wire                    stall,
	input  wire                    redirect,
	input  wire word_t             redirect_pc,
	input  wire word_t             I_MEM_DI,
	output logic [IMEM_ADDR_W-1:0] I_MEM_ADDR,
	output if_id_t                 if_id
);

	logic [IMEM_ADDR_W-1:0] pc_q;

	assign I_MEM_ADDR = pc_q;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc_q <= '0;
		end else if (redirect) begin
			pc_q <= redirect_pc[IMEM_ADDR_W-1:0];
		end else if (!stall) begin
			pc_q <= pc_q + IMEM_ADDR_W'(4);   // wraps inside imem
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			if_id.valid <= 1'b0;
		end else if (redirect) begin
			if_id.valid <= 1'b0;   // squash wrong-path fetch
		end else if (!stall) begin
			if_id.valid <= 1'b1;
			if_id.pc    <= {{(XLEN-IMEM_ADDR_W){1'b0}}, pc_q};
			if_id.instr <= I_MEM_DI;
		end
	end

	a_pc_aligned: assert property (@(posedge CLK) disable iff (RSTn)
		I_MEM_ADDR[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_idx_t;

	// major opcodes, encoded as in the ISA
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_LINK   // pc+4
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// stage registers

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} rf_write_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		opcode_e  opcode;
		alu_op_e  alu_op;
		logic [2:0] funct3;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		logic     rd_we;
		word_t    rs1_val;
		word_t    rs2_val;
		word_t    imm;
		word_t    pc;
		logic     use_imm;   // operand b from imm
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		opcode_e  opcode;
		reg_idx_t rd;
		logic     rd_we;
		word_t    result;
		word_t    store_data;
	} ex_mem_t;

endpackage

`default_nettype wire
